// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - logic/lsu_isa_pkg.sv
      - logic/lsu_pipe_pkg.sv
      - logic/lsu_agu.sv
      - logic/lsu_ex.sv
      - logic/lsu_dmem.sv
      - logic/lsu_wb.sv
      - logic/lsu_top.sv
  - target: test
    files:
      - tb/lsu_assertions.sv
      - tb/lsu_tb.sv

// File: include/lsu_defines.svh
/* LSU common width definitions shared by the architectural and pipeline type packages */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Width of a data word moved between the register file and memory
`define LSU_DATA_WIDTH 32

// Width of a byte address
`define LSU_ADDR_WIDTH 32

// Width of the destination tag that travels with each operation
`define LSU_TAG_WIDTH 6

`endif

// File: logic/lsu_agu.sv
/* LSU address generation stage: effective address, alignment check and store lane
   placement, registered in front of execute */

`timescale 1ns/1ps
`default_nettype none

module lsu_agu import lsu_isa_pkg::*, lsu_pipe_pkg::*; (
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    // Issued operation, one-cycle strobe with no ready
    input  wire logic       i_op_valid,
    input  wire lsu_op_t    i_op,

    // Registered payload for execute
    output lsu_ag_ex_t      o_ag_ex
);

    lsu_addr_t  addr;
    lsu_ag_ex_t ag_d;
    lsu_ag_ex_t ag_q;
    logic       valid_q;

    // Effective address is base plus offset, wrapping at the address width
    assign addr = i_op.base + i_op.offset;

    always_comb begin
        ag_d            = '0;
        ag_d.valid      = i_op_valid;
        ag_d.func       = i_op.func;
        ag_d.addr       = addr;
        ag_d.tag        = i_op.tag;

        // Halfwords need an even address and words need a word-aligned one
        case (i_op.func)
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: ag_d.misaligned = addr[0];
            LSU_FUNC_LW, LSU_FUNC_SW:               ag_d.misaligned = |addr[1:0];
            default:                                ag_d.misaligned = 1'b0;
        endcase

        // Place store bytes in the lanes they will occupy in memory
        // Loads leave every enable clear
        case (i_op.func)
            LSU_FUNC_SB: begin
                ag_d.wdata.bytes[addr[1:0]] = i_op.wdata[7:0];
                ag_d.be[addr[1:0]]          = 1'b1;
            end
            LSU_FUNC_SH: begin
                // Upper address bit picks the half, odd addresses are caught as faults
                ag_d.wdata.bytes[{addr[1], 1'b0}] = i_op.wdata[7:0];
                ag_d.wdata.bytes[{addr[1], 1'b1}] = i_op.wdata[15:8];
                ag_d.be[{addr[1], 1'b0}]          = 1'b1;
                ag_d.be[{addr[1], 1'b1}]          = 1'b1;
            end
            LSU_FUNC_SW: begin
                ag_d.wdata.word = i_op.wdata;
                ag_d.be         = '1;
            end
            default: begin
            end
        endcase
    end

    // Only the valid bit needs a known state out of reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_op_valid;
        end
    end

    always_ff @(posedge clk) begin
        ag_q <= ag_d;
    end

    always_comb begin
        o_ag_ex       = ag_q;
        o_ag_ex.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: logic/lsu_dmem.sv
/* LSU data memory: word-organized scratchpad with combinational read and
   byte-enabled writes */

`timescale 1ns/1ps
`default_nettype none

module lsu_dmem import lsu_isa_pkg::*, lsu_pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  wire logic                   clk,

    input  wire lsu_addr_t              i_addr,
    input  wire logic                   i_re,
    input  wire logic                   i_we,
    input  wire logic [LSU_BYTES-1:0]   i_be,
    input  wire lsu_word_u              i_wdata,

    output lsu_word_u                   o_rdata,
    output logic                        o_hit
);

    // Index bits sit just above the byte offset
    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    lsu_word_u          mem [DMEM_WORDS];
    logic [IDX_W-1:0]   idx;

    // Higher address bits are dropped so accesses wrap around the array
    assign idx = i_addr[IDX_W+1:2];

    // Read data is available in the same cycle as the address
    assign o_rdata = mem[idx];

    // A scratchpad never misses, so every read is a hit
    assign o_hit = i_re;

    // Only the enabled lanes are overwritten, the others keep their bytes
    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int i = 0; i < LSU_BYTES; i++) begin
                if (i_be[i]) begin
                    mem[idx].bytes[i] <= i_wdata.bytes[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_ex.sv
/* LSU execute stage: accesses the data memory, extracts and extends load data and
   completes aligned stores */

`timescale 1ns/1ps
`default_nettype none

module lsu_ex import lsu_isa_pkg::*, lsu_pipe_pkg::*; (
    // Payload from address generation
    input  wire lsu_ag_ex_t         i_ag_ex,

    // Result for writeback
    output lsu_ex_wb_t              o_ex_wb,

    // Data memory port
    // The hit input stays unconnected inside since the scratchpad always hits
    input  wire logic               i_dc_hit,
    input  wire lsu_word_u          i_dc_rdata,
    output lsu_addr_t               o_dc_addr,
    output logic                    o_dc_re,
    output logic                    o_dc_we,
    output logic [LSU_BYTES-1:0]    o_dc_be,
    output lsu_word_u               o_dc_wdata
);

    logic       is_load;
    logic       is_store;
    lsu_data_t  lane;
    lsu_data_t  ld_data;

    assign is_load  = i_ag_ex.func inside {LSU_FUNC_LB, LSU_FUNC_LH, LSU_FUNC_LW,
                                           LSU_FUNC_LBU, LSU_FUNC_LHU};
    assign is_store = i_ag_ex.func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};

    // Memory is read for every valid load
    assign o_dc_addr  = i_ag_ex.addr;
    assign o_dc_re    = i_ag_ex.valid & is_load;

    // Stores are written at the end of this cycle unless misaligned
    assign o_dc_we    = i_ag_ex.valid & is_store & ~i_ag_ex.misaligned;
    assign o_dc_be    = i_ag_ex.be;
    assign o_dc_wdata = i_ag_ex.wdata;

    // Bring the addressed lane down to bit 0
    assign lane = i_dc_rdata.word >> {i_ag_ex.addr[1:0], 3'b000};

    // Signed loads copy the top bit of the lane upward, unsigned ones fill with zero
    always_comb begin
        case (i_ag_ex.func)
            LSU_FUNC_LB:  ld_data = {{(LSU_DATA_W-8){lane[7]}}, lane[7:0]};
            LSU_FUNC_LH:  ld_data = {{(LSU_DATA_W-16){lane[15]}}, lane[15:0]};
            LSU_FUNC_LBU: ld_data = {{(LSU_DATA_W-8){1'b0}}, lane[7:0]};
            LSU_FUNC_LHU: ld_data = {{(LSU_DATA_W-16){1'b0}}, lane[15:0]};
            default:      ld_data = lane;
        endcase
    end

    // Loads and stores both complete here, so valid passes straight through
    // Faulting loads and all stores carry zero data
    always_comb begin
        o_ex_wb         = '0;
        o_ex_wb.valid   = i_ag_ex.valid;
        o_ex_wb.is_load = is_load;
        o_ex_wb.fault   = i_ag_ex.misaligned;
        o_ex_wb.addr    = i_ag_ex.addr;
        o_ex_wb.tag     = i_ag_ex.tag;
        if (is_load && !i_ag_ex.misaligned) begin
            o_ex_wb.data = ld_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_isa_pkg.sv
/* LSU architectural types: function codes and the data, address and tag words */

`default_nettype none

`include "lsu_defines.svh"

package lsu_isa_pkg;

    // Data width as a constant so modules can size extension fields
    localparam int LSU_DATA_W = `LSU_DATA_WIDTH;

    // One data word as seen by the register file
    typedef logic [`LSU_DATA_WIDTH-1:0] lsu_data_t;

    // Byte address into the data memory
    typedef logic [`LSU_ADDR_WIDTH-1:0] lsu_addr_t;

    // Destination tag returned with the result
    typedef logic [`LSU_TAG_WIDTH-1:0]  lsu_tag_t;

    // Memory operation codes
    // Loads come first so sub-word loads share the low encodings
    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'd0,
        LSU_FUNC_LH  = 4'd1,
        LSU_FUNC_LW  = 4'd2,
        LSU_FUNC_LBU = 4'd3,
        LSU_FUNC_LHU = 4'd4,
        LSU_FUNC_SB  = 4'd5,
        LSU_FUNC_SH  = 4'd6,
        LSU_FUNC_SW  = 4'd7
    } lsu_func_t;

endpackage

`default_nettype wire

// File: logic/lsu_pipe_pkg.sv
/* LSU pipeline types: issued operations, stage-to-stage payloads and the memory word */

`default_nettype none

`include "lsu_defines.svh"

package lsu_pipe_pkg;

    import lsu_isa_pkg::*;

    // Number of byte lanes in one memory word
    localparam int LSU_BYTES = `LSU_DATA_WIDTH / 8;

    // One memory word, read either as a whole or lane by lane
    // The store path and the memory merge bytes through the byte view
    typedef union packed {
        lsu_data_t                  word;
        logic [LSU_BYTES-1:0][7:0]  bytes;
    } lsu_word_u;

    // Operation as it arrives from issue
    typedef struct packed {
        lsu_func_t  func;
        lsu_addr_t  base;
        lsu_data_t  offset;
        lsu_data_t  wdata;
        lsu_tag_t   tag;
    } lsu_op_t;

    // Address generation to execute
    typedef struct packed {
        logic                   valid;
        lsu_func_t              func;
        lsu_addr_t              addr;
        lsu_word_u              wdata;
        logic [LSU_BYTES-1:0]   be;
        logic                   misaligned;
        lsu_tag_t               tag;
    } lsu_ag_ex_t;

    // Execute to writeback
    typedef struct packed {
        logic       valid;
        logic       is_load;
        logic       fault;
        lsu_data_t  data;
        lsu_addr_t  addr;
        lsu_tag_t   tag;
    } lsu_ex_wb_t;

endpackage

`default_nettype wire

// File: logic/lsu_top.sv
/* LSU top level: address generation, execute with its data memory, and writeback */

`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_isa_pkg::*, lsu_pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    // Issue side
    input  wire logic       i_op_valid,
    input  wire lsu_op_t    i_op,

    // Writeback side, to be taken in the cycle it is valid
    output logic            o_valid,
    output logic            o_rd_we,
    output logic            o_fault,
    output lsu_tag_t        o_tag,
    output lsu_addr_t       o_addr,
    output lsu_data_t       o_data
);

    lsu_ag_ex_t             ag_ex;
    lsu_ex_wb_t             ex_wb;

    // Execute to data memory
    lsu_addr_t              dc_addr;
    logic                   dc_re;
    logic                   dc_we;
    logic [LSU_BYTES-1:0]   dc_be;
    lsu_word_u              dc_wdata;
    lsu_word_u              dc_rdata;
    logic                   dc_hit;

    lsu_agu agu_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_op_valid (i_op_valid),
        .i_op       (i_op),
        .o_ag_ex    (ag_ex)
    );

    lsu_ex ex_i (
        .i_ag_ex    (ag_ex),
        .o_ex_wb    (ex_wb),
        .i_dc_hit   (dc_hit),
        .i_dc_rdata (dc_rdata),
        .o_dc_addr  (dc_addr),
        .o_dc_re    (dc_re),
        .o_dc_we    (dc_we),
        .o_dc_be    (dc_be),
        .o_dc_wdata (dc_wdata)
    );

    lsu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dmem_i (
        .clk        (clk),
        .i_addr     (dc_addr),
        .i_re       (dc_re),
        .i_we       (dc_we),
        .i_be       (dc_be),
        .i_wdata    (dc_wdata),
        .o_rdata    (dc_rdata),
        .o_hit      (dc_hit)
    );

    lsu_wb wb_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_ex_wb    (ex_wb),
        .o_valid    (o_valid),
        .o_rd_we    (o_rd_we),
        .o_fault    (o_fault),
        .o_tag      (o_tag),
        .o_addr     (o_addr),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

// File: logic/lsu_wb.sv
/* LSU writeback register: returns the tagged result and raises write enable or fault */

`timescale 1ns/1ps
`default_nettype none

module lsu_wb import lsu_isa_pkg::*, lsu_pipe_pkg::*; (
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    input  wire lsu_ex_wb_t i_ex_wb,

    output logic            o_valid,
    output logic            o_rd_we,
    output logic            o_fault,
    output lsu_tag_t        o_tag,
    output lsu_addr_t       o_addr,
    output lsu_data_t       o_data
);

    // Control bits come out of reset cleared
    // Register file is written only for a load that did not fault
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_rd_we <= 1'b0;
            o_fault <= 1'b0;
        end else begin
            o_valid <= i_ex_wb.valid;
            o_rd_we <= i_ex_wb.valid & i_ex_wb.is_load & ~i_ex_wb.fault;
            o_fault <= i_ex_wb.valid & i_ex_wb.fault;
        end
    end

    // Result fields are only meaningful while o_valid is high
    always_ff @(posedge clk) begin
        o_tag  <= i_ex_wb.tag;
        o_addr <= i_ex_wb.addr;
        o_data <= i_ex_wb.data;
    end

endmodule

`default_nettype wire

// File: lsu.f
+incdir+include
logic/lsu_isa_pkg.sv
logic/lsu_pipe_pkg.sv
logic/lsu_agu.sv
logic/lsu_ex.sv
logic/lsu_dmem.sv
logic/lsu_wb.sv
logic/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

// File: tb/lsu_assertions.sv
/* LSU pipeline checks bound into lsu_top: writeback flags, result latency and
   suppression of misaligned stores */

`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
    input wire logic    clk,
    input wire logic    i_arst_n,
    input wire logic    i_op_valid,
    input wire logic    i_valid,
    input wire logic    i_rd_we,
    input wire logic    i_fault,
    input wire logic    i_ex_misaligned,
    input wire logic    i_dc_we
);

    // A register write needs a valid result that did not fault
    rd_we_clean: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_rd_we |-> (i_valid && !i_fault))
        else $error("o_rd_we high without a valid fault-free result");

    // The strobe sampled at one edge shows up as o_valid sampled two edges later
    result_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_valid |-> $past(i_op_valid, 2)) and ($past(i_op_valid, 2) |-> i_valid))
        else $error("o_valid did not follow i_op_valid by two cycles");

    // Misaligned accesses never reach the data memory
    no_misaligned_write: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_ex_misaligned |-> !i_dc_we)
        else $error("data memory written by a misaligned access");

endmodule

bind lsu_top lsu_assertions assertions_i (
    .clk                (clk),
    .i_arst_n           (i_arst_n),
    .i_op_valid         (i_op_valid),
    .i_valid            (o_valid),
    .i_rd_we            (o_rd_we),
    .i_fault            (o_fault),
    .i_ex_misaligned    (ag_ex.misaligned),
    .i_dc_we            (dc_we)
);

`default_nettype wire

// File: tb/lsu_tb.sv
/* LSU directed testbench: drives loads and stores through lsu_top and checks every
   tagged result against a byte-level memory model */

`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_isa_pkg::*, lsu_pipe_pkg::*; ();

    localparam int DMEM_WORDS   = 64;
    localparam int MEM_BYTES    = DMEM_WORDS * 4;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    // Upper bound on issue and idle cycles over all tests
    localparam int NUM_OPS      = 180;

    // Result expected on the writeback outputs for one issue slot
    typedef struct packed {
        logic       valid;
        logic       rd_we;
        logic       fault;
        lsu_tag_t   tag;
        lsu_addr_t  addr;
        lsu_data_t  data;
    } result_t;

    logic       clk = 1'b0;
    logic       i_arst_n;
    logic       i_op_valid;
    lsu_op_t    i_op;
    logic       o_valid;
    logic       o_rd_we;
    logic       o_fault;
    lsu_tag_t   o_tag;
    lsu_addr_t  o_addr;
    lsu_data_t  o_data;

    // Byte model of the data memory, updated in issue order
    logic [7:0]     model_mem [MEM_BYTES];
    // Slot 1 holds the result due on the outputs at the coming falling edge
    result_t        pending [2];
    logic [31:0]    lfsr_state;
    lsu_tag_t       tag_next;

    lsu_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_op_valid (i_op_valid),
        .i_op       (i_op),
        .o_valid    (o_valid),
        .o_rd_we    (o_rd_we),
        .o_fault    (o_fault),
        .o_tag      (o_tag),
        .o_addr     (o_addr),
        .o_data     (o_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Four clock periods per cycle of traffic, plus the reset phase
    initial begin
        #(NUM_OPS * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before all tests finished");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input lsu_data_t exp, input lsu_data_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input lsu_addr_t exp, input lsu_addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input lsu_tag_t exp, input lsu_tag_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0]    v;
        logic           lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'hd000_0001;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    // Expected result of one operation; aligned stores also update the model
    function automatic result_t predict(input lsu_op_t op);
        result_t        r;
        lsu_addr_t      addr;
        logic [31:0]    raw;
        logic           is_store;
        int             idx;
        int             size;
        addr     = op.base + op.offset;
        idx      = int'(addr % MEM_BYTES);
        is_store = op.func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};
        size     = (op.func inside {LSU_FUNC_LW, LSU_FUNC_SW}) ? 4 :
                   (op.func inside {LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH}) ? 2 : 1;
        r       = '0;
        r.valid = 1'b1;
        r.tag   = op.tag;
        r.addr  = addr;
        r.fault = (addr % size) != 0;
        raw     = '0;
        for (int k = 0; k < size; k++) begin
            raw[8*k +: 8] = model_mem[(idx + k) % MEM_BYTES];
            if (is_store && !r.fault) begin
                model_mem[(idx + k) % MEM_BYTES] = op.wdata[8*k +: 8];
            end
        end
        // Bytes above the access size are already zero, which covers LW, LBU and LHU
        if (!is_store && !r.fault) begin
            r.rd_we = 1'b1;
            case (op.func)
                LSU_FUNC_LB: r.data = {{24{raw[7]}}, raw[7:0]};
                LSU_FUNC_LH: r.data = {{16{raw[15]}}, raw[15:0]};
                default:     r.data = raw;
            endcase
        end
        return r;
    endfunction

    task automatic check_outputs(input result_t exp);
        if (exp.valid && o_valid !== 1'b1) begin
            fail_run($sformatf("no result on o_valid for tag %0d at %0t", exp.tag, $time));
        end
        check_flag("o_valid", exp.valid, o_valid);
        check_flag("o_rd_we", exp.rd_we, o_rd_we);
        check_flag("o_fault", exp.fault, o_fault);
        if (exp.valid) begin
            check_tag("o_tag", exp.tag, o_tag);
            check_addr("o_addr", exp.addr, o_addr);
            check_data("o_data", exp.data, o_data);
        end
    endtask

    // Each falling edge checks the slot issued two edges earlier, then drives the next one
    task automatic advance_cycle(input logic valid, input lsu_op_t op, input result_t exp);
        @(negedge clk);
        check_outputs(pending[1]);
        pending[1] = pending[0];
        pending[0] = exp;
        i_op_valid = valid;
        i_op       = op;
    endtask

    task automatic issue(input lsu_func_t func, input lsu_addr_t base, input lsu_data_t offset,
                         input lsu_data_t wdata);
        lsu_op_t op;
        op.func   = func;
        op.base   = base;
        op.offset = offset;
        op.wdata  = wdata;
        op.tag    = tag_next;
        tag_next  = tag_next + 1'b1;
        advance_cycle(1'b1, op, predict(op));
    endtask

    task automatic idle(input int n);
        repeat (n) advance_cycle(1'b0, '0, '0);
    endtask

    // Flags stay low out of reset until the first strobe has had two cycles to return
    task automatic test_reset_state();
        check_flag("o_valid", 1'b0, o_valid);
        check_flag("o_rd_we", 1'b0, o_rd_we);
        check_flag("o_fault", 1'b0, o_fault);
        idle(4);
        issue(LSU_FUNC_SW, '0, '0, 32'h1234_5678);
        idle(3);
    endtask

    // Every word gets a value built from its full byte address
    task automatic fill_memory();
        lsu_addr_t a;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            a = lsu_addr_t'(4 * w);
            issue(LSU_FUNC_SW, a, '0, (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]});
        end
        idle(3);
    endtask

    // Random high address bits also exercise the wrap around the memory size
    task automatic test_word_store_load();
        lsu_addr_t a;
        lsu_data_t d;
        for (int i = 0; i < 4; i++) begin
            a = lfsr_bits(32) & 32'hffff_fffc;
            d = lfsr_bits(32);
            issue(LSU_FUNC_SW, a, '0, d);
            idle(1);
            issue(LSU_FUNC_LW, '0, a, '0);
        end
        idle(3);
    endtask

    task automatic test_subword_loads();
        lsu_data_t words [2];
        lsu_addr_t a;
        words[0] = 32'h8a7f_c435;
        words[1] = 32'h7f80_01fe;
        for (int w = 0; w < 2; w++) begin
            a = lsu_addr_t'(32'h40 + 4 * w);
            issue(LSU_FUNC_SW, a, '0, words[w]);
            for (int b = 0; b < 4; b++) begin
                issue(LSU_FUNC_LB, a, b, '0);
                issue(LSU_FUNC_LBU, a, b, '0);
            end
            for (int h = 0; h < 4; h += 2) begin
                issue(LSU_FUNC_LH, a, h, '0);
                issue(LSU_FUNC_LHU, a, h, '0);
            end
        end
        idle(3);
    endtask

    // Store data carries random upper bits that must not reach memory
    task automatic test_byte_stores();
        for (int b = 0; b < 4; b++) begin
            issue(LSU_FUNC_SB, 32'h80, b, lfsr_bits(32));
            issue(LSU_FUNC_LW, 32'h80, '0, '0);
        end
        for (int h = 0; h < 4; h += 2) begin
            issue(LSU_FUNC_SH, 32'h84, h, lfsr_bits(32));
            issue(LSU_FUNC_LW, 32'h84, '0, '0);
        end
        idle(3);
    endtask

    task automatic test_back_to_back();
        lsu_func_t f;
        lsu_data_t off;
        lsu_data_t d;
        issue(LSU_FUNC_SW, 32'hc0, '0, lfsr_bits(32));
        issue(LSU_FUNC_LW, 32'hc0, '0, '0);
        for (int i = 0; i < 16; i++) begin
            f   = lsu_func_t'(lfsr_bits(3));
            off = lfsr_bits(8);
            d   = lfsr_bits(32);
            issue(f, '0, off, d);
        end
        idle(3);
    endtask

    // Faulting stores leave both neighbouring words as they were
    task automatic test_misaligned();
        issue(LSU_FUNC_LH, 32'h20, 1, '0);
        issue(LSU_FUNC_LHU, 32'h20, 3, '0);
        issue(LSU_FUNC_LW, 32'h20, 1, '0);
        issue(LSU_FUNC_LW, 32'h20, 2, '0);
        issue(LSU_FUNC_LW, 32'h20, 3, '0);
        issue(LSU_FUNC_SW, 32'h20, 2, 32'hdead_beef);
        issue(LSU_FUNC_SH, 32'h20, 1, 32'h0000_a5a5);
        issue(LSU_FUNC_LW, 32'h20, '0, '0);
        issue(LSU_FUNC_LW, 32'h24, '0, '0);
        idle(3);
    endtask

    initial begin
        i_arst_n   = 1'b0;
        i_op_valid = 1'b0;
        i_op       = '0;
        lfsr_state = 32'hea6a_156f;
        tag_next   = '0;
        for (int i = 0; i < 2; i++) begin
            pending[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        i_arst_n = 1'b1;
        test_reset_state();
        fill_memory();
        test_word_store_load();
        test_subword_loads();
        test_byte_stores();
        test_back_to_back();
        test_misaligned();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
